// ==== command_parser.sv ====
`timescale 1ns/1ns

module command_parser (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid,
    output logic [2:0]            rgb_enable,
    output logic [5:0]            brightness_enable,
    output led_cfg_pkg::ram_addr_u wr_addr,
    output logic [7:0]            wr_data,
    output logic                  wr_en,
    output logic                  line_busy,
    output logic [7:0]            lines_done
);

    uart_cmd_pkg::line_state_e state;
    logic [6:0]                byte_cnt;  // Counts down over one line
    logic [4:0]                row;
    logic                      last_byte;
    logic                      row_byte;

    assign line_busy = (state != uart_cmd_pkg::ST_IDLE);
    assign last_byte = (byte_cnt == 7'd0);

    // Second L right after L is not taken as a row
    assign row_byte = (state == uart_cmd_pkg::ST_ROW) && (rx_byte != uart_cmd_pkg::CMD_LINE);

    // ****************************************
    // Command decode and line sequencing
    // ****************************************

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= uart_cmd_pkg::ST_IDLE;
            byte_cnt          <= '0;
            wr_en             <= 1'b0;
            rgb_enable        <= 3'b111;
            brightness_enable <= 6'b111111;
            lines_done        <= '0;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    uart_cmd_pkg::ST_IDLE: begin
                        case (rx_byte)
                            uart_cmd_pkg::CMD_RED_ON: begin
                                rgb_enable[0] <= 1'b1;
                            end
                            uart_cmd_pkg::CMD_RED_OFF: begin
                                rgb_enable[0] <= 1'b0;
                            end
                            uart_cmd_pkg::CMD_GREEN_ON: begin
                                rgb_enable[1] <= 1'b1;
                            end
                            uart_cmd_pkg::CMD_GREEN_OFF: begin
                                rgb_enable[1] <= 1'b0;
                            end
                            uart_cmd_pkg::CMD_BLUE_ON: begin
                                rgb_enable[2] <= 1'b1;
                            end
                            uart_cmd_pkg::CMD_BLUE_OFF: begin
                                rgb_enable[2] <= 1'b0;
                            end
                            // Plane digits count down from the MSB
                            uart_cmd_pkg::CMD_PLANE_1: begin
                                brightness_enable[5] <= ~brightness_enable[5];
                            end
                            uart_cmd_pkg::CMD_PLANE_2: begin
                                brightness_enable[4] <= ~brightness_enable[4];
                            end
                            uart_cmd_pkg::CMD_PLANE_3: begin
                                brightness_enable[3] <= ~brightness_enable[3];
                            end
                            uart_cmd_pkg::CMD_PLANE_4: begin
                                brightness_enable[2] <= ~brightness_enable[2];
                            end
                            uart_cmd_pkg::CMD_PLANE_5: begin
                                brightness_enable[1] <= ~brightness_enable[1];
                            end
                            uart_cmd_pkg::CMD_PLANE_6: begin
                                brightness_enable[0] <= ~brightness_enable[0];
                            end
                            uart_cmd_pkg::CMD_PLANES_OFF: begin
                                brightness_enable <= 6'b000000;
                            end
                            uart_cmd_pkg::CMD_PLANES_ON: begin
                                brightness_enable <= 6'b111111;
                            end
                            uart_cmd_pkg::CMD_LINE: begin
                                state <= uart_cmd_pkg::ST_ROW;
                            end
                            default: begin
                                state <= uart_cmd_pkg::ST_IDLE;  // Unknown byte
                            end
                        endcase
                    end
                    uart_cmd_pkg::ST_ROW: begin
                        if (row_byte) begin
                            byte_cnt <= 7'(led_cfg_pkg::BYTES_PER_LINE - 1);
                            state    <= uart_cmd_pkg::ST_DATA;
                        end
                    end
                    uart_cmd_pkg::ST_DATA: begin
                        wr_en <= 1'b1;  // One write per data byte
                        if (last_byte) begin
                            state      <= uart_cmd_pkg::ST_IDLE;
                            lines_done <= lines_done + 8'd1;  // Wraps at 256
                        end else begin
                            byte_cnt <= byte_cnt - 7'd1;
                        end
                    end
                    default: begin
                        state <= uart_cmd_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // ****************************************
    // Write address and data
    // ****************************************

    // First byte of a pixel pair lands at byte select 1
    always_ff @(posedge clk_in) begin
        if (rx_valid && row_byte) begin
            row <= rx_byte[4:0];
        end
        if (rx_valid && state == uart_cmd_pkg::ST_DATA) begin
            wr_data                <= rx_byte;
            wr_addr.field.row      <= row;
            wr_addr.field.pixel    <= 6'(led_cfg_pkg::MATRIX_COLS - 1) - byte_cnt[6:1];
            wr_addr.field.byte_sel <= byte_cnt[0];
        end
    end

endmodule

// ==== frame_ram.sv ====
`timescale 1ns/1ns

module frame_ram (
    input  logic                                 clk_in,
    input  logic                                 wr_en,
    input  led_cfg_pkg::ram_addr_u               wr_addr,
    input  logic [led_cfg_pkg::RAM_DATA_W-1:0]   wr_data,
    input  logic [led_cfg_pkg::RAM_ADDR_W-1:0]   scan_addr,
    output logic [led_cfg_pkg::RAM_DATA_W-1:0]   scan_data
);

    // ****************************************
    // Storage, one byte per half pixel
    // ****************************************

    logic [led_cfg_pkg::RAM_DATA_W-1:0]
        mem [0:led_cfg_pkg::MATRIX_ROWS * led_cfg_pkg::BYTES_PER_LINE - 1];

    // Parser side
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr.flat] <= wr_data;
        end
    end

    // Scanner side, old data on a same-address write
    always_ff @(posedge clk_in) begin
        scan_data <= mem[scan_addr];
    end

endmodule

// ==== led_asserts.sv ====
`timescale 1ns/1ns

module led_asserts (
    input logic clk_in,
    input logic reset,
    input logic wr_en,
    input logic line_busy,
    input logic rx_valid
);

    int fail_count = 0;  // Read by the testbench at the end

    // The last write of a line comes as line_busy falls
    write_in_line: assert property (@(posedge clk_in) disable iff (reset)
        wr_en |-> $past(line_busy))
        else begin
            fail_count++;
            $error("wr_en high without an open line load");
        end

    write_single: assert property (@(posedge clk_in) disable iff (reset)
        wr_en |=> !wr_en)
        else begin
            fail_count++;
            $error("wr_en high on two consecutive cycles");
        end

    // One strobe per received byte
    valid_single: assert property (@(posedge clk_in) disable iff (reset)
        rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid longer than one cycle");
        end

endmodule

bind command_parser led_asserts u_led_asserts (
    .clk_in   (clk_in),
    .reset    (reset),
    .wr_en    (wr_en),
    .line_busy(line_busy),
    .rx_valid (rx_valid)
);

// ==== led_cfg_pkg.sv ====
package led_cfg_pkg;

    // ****************************************
    // Matrix geometry
    // ****************************************

    localparam int MATRIX_ROWS    = 32;  // Rows in the frame buffer
    localparam int MATRIX_COLS    = 64;  // Pixels per row
    localparam int BYTES_PER_LINE = 128; // Two bytes per pixel

    localparam int RAM_ADDR_W = 12;
    localparam int RAM_DATA_W = 8;

    // ****************************************
    // UART timing
    // ****************************************

    // clk_in cycles per serial bit
    localparam int UART_TICKS_PER_BIT = 9;

    // ****************************************
    // Frame buffer address
    // ****************************************

    // Same 12 bits seen as one word or as row / pixel / byte fields
    typedef union packed {
        logic [RAM_ADDR_W-1:0] flat;               // Word address for the RAM
        struct packed {
            logic [$clog2(MATRIX_ROWS)-1:0] row;   // Display row
            logic [$clog2(MATRIX_COLS)-1:0] pixel; // Pixel within the row
            logic                           byte_sel; // High or low byte
        } field;
    } ram_addr_u;

endpackage

// ==== led_matrix_ctrl.sv ====
`timescale 1ns/1ns

module led_matrix_ctrl (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        uart_rx,
    input  logic [11:0] scan_addr,
    output logic [7:0]  scan_data,
    output logic [2:0]  rgb_enable,
    output logic [5:0]  brightness_enable,
    output logic        rx_busy,
    output logic        line_busy,
    output logic [7:0]  lines_done
);

    logic [7:0]             rx_byte;
    logic                   rx_valid;
    led_cfg_pkg::ram_addr_u wr_addr;
    logic [7:0]             wr_data;
    logic                   wr_en;

    // ****************************************
    // Serial input
    // ****************************************

    uart_rx #(
        .ticks_per_bit(led_cfg_pkg::UART_TICKS_PER_BIT)
    ) u_uart_rx (
        .clk_in  (clk_in),
        .reset   (reset),
        .uart_rx (uart_rx),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid),
        .rx_busy (rx_busy)
    );

    command_parser u_command_parser (
        .clk_in           (clk_in),
        .reset            (reset),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_en            (wr_en),
        .line_busy        (line_busy),
        .lines_done       (lines_done)
    );

    // Scanner reads through the second port
    frame_ram u_frame_ram (
        .clk_in   (clk_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .scan_addr(scan_addr),
        .scan_data(scan_data)
    );

endmodule

// ==== led_trace.txt ====
# T name | S byte(hex) | X byte(hex), low stop bit | P row(dec) seed(hex) | M row(dec) seed(hex)
# E rgb(bin, bit 2 blue) brightness(bin) lines_done(dec)
T reset_values
E 111 111111 0
T channel_cmds
S 72
S 67
S 42
S 47
E 110 111111 0
S 41
S 7a
E 110 111111 0
T brightness_cmds
S 30
S 31
S 36
S 31
E 110 000001 0
S 39
E 110 111111 0
T line_row5
P 5 7fc7
E 110 111111 1
M 5 7fc7
T row_byte_rule
S 30
S 36
E 110 000001 1
S 4c
P 3 7fc7
E 110 000001 2
M 3 7fc7
M 5 7fc7
T bad_stop
S 52
E 111 000001 2
X 72
E 111 000001 2
S 72
E 110 000001 2

// ==== sim.f ====
led_cfg_pkg.sv
uart_cmd_pkg.sv
uart_rx.sv
command_parser.sv
frame_ram.sv
led_matrix_ctrl.sv
led_asserts.sv
tb_led_matrix.sv

// ==== tb_led_matrix.sv ====
`timescale 1ns/1ns

module tb_led_matrix;

    localparam int BIT_CYCLES = led_cfg_pkg::UART_TICKS_PER_BIT;
    localparam int LINE_BYTES = led_cfg_pkg::BYTES_PER_LINE;
    localparam int WAIT_LIMIT = 4000;  // Cycles before any wait gives up

    logic        clk_in;
    logic        reset;
    logic        uart_rx;
    logic [11:0] scan_addr;
    logic [7:0]  scan_data;
    logic [2:0]  rgb_enable;
    logic [5:0]  brightness_enable;
    logic        rx_busy;
    logic        line_busy;
    logic [7:0]  lines_done;

    logic [31:0] lfsr_state;
    logic [7:0]  exp_row [0:LINE_BYTES-1];  // Expected pixel stream of one line
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          checks_run;

    led_matrix_ctrl dut (
        .clk_in           (clk_in),
        .reset            (reset),
        .uart_rx          (uart_rx),
        .scan_addr        (scan_addr),
        .scan_data        (scan_data),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .rx_busy          (rx_busy),
        .line_busy        (line_busy),
        .lines_done       (lines_done)
    );

    initial clk_in = 1'b0;
    always #5 clk_in = ~clk_in;  // 10 ns period

    // ****************************************
    // Stimulus helpers
    // ****************************************

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic fill_expected_row(input logic [31:0] seed);
        logic [7:0] value;
        lfsr_state = seed;
        for (int k = 0; k < LINE_BYTES; k++) begin
            for (int b = 0; b < 8; b++) begin
                value[b]   = lfsr_state[0];  // One step per bit
                lfsr_state = lfsr_next(lfsr_state);
            end
            exp_row[k] = value;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $finish;
    endtask

    task automatic wait_rx_idle();
        int cycles;
        cycles = 0;
        while (rx_busy && cycles < WAIT_LIMIT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (rx_busy) begin
            abort_run($sformatf("Receiver never went idle in test %s", test_name));
        end
    endtask

    task automatic wait_line_idle();
        int cycles;
        cycles = 0;
        while (line_busy && cycles < WAIT_LIMIT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (line_busy) begin
            abort_run($sformatf("Line load never finished in test %s", test_name));
        end
    endtask

    task automatic wait_cycles(input int count);
        int cycles;
        cycles = 0;
        while (cycles < count && cycles < WAIT_LIMIT) begin
            @(negedge clk_in);
            cycles++;
        end
    endtask

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] value, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_in);
            uart_rx = frame[i];
            if (i == 5 && rx_busy !== 1'b1) begin  // Receiver busy inside the frame
                report_error("rx_busy mid frame", 32'd1, rx_busy);
            end
            repeat (BIT_CYCLES - 1) @(negedge clk_in);
        end
        @(negedge clk_in);
        uart_rx = 1'b1;  // Line back to idle
        wait_rx_idle();
    endtask

    task automatic send_line(input int row, input logic [31:0] seed);
        fill_expected_row(seed);
        send_byte(uart_cmd_pkg::CMD_LINE, 1'b0);
        send_byte(8'(row), 1'b0);
        for (int k = 0; k < LINE_BYTES; k++) begin
            send_byte(exp_row[k], 1'b0);
        end
        wait_line_idle();
    endtask

    // ****************************************
    // Checking and reporting
    // ****************************************

    task automatic report_error(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERROR %s: %s expected 'h%0h actual 'h%0h", test_name, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_field_count(input int got, input int want, input string kind);
        if (got != want) begin
            $display("Malformed trace line %s in test %s", kind, test_name);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_outputs(input logic [2:0] exp_rgb, input logic [5:0] exp_bright,
                                 input logic [7:0] exp_lines);
        wait_cycles(4);  // Let the last command settle
        checks_run++;
        if (rgb_enable !== exp_rgb) begin
            report_error("rgb_enable", exp_rgb, rgb_enable);
        end
        if (brightness_enable !== exp_bright) begin
            report_error("brightness_enable", exp_bright, brightness_enable);
        end
        if (lines_done !== exp_lines) begin
            report_error("lines_done", exp_lines, lines_done);
        end
        if (line_busy !== 1'b0) begin
            report_error("line_busy", 32'd0, line_busy);
        end
        if (rx_busy !== 1'b0) begin
            report_error("rx_busy", 32'd0, rx_busy);
        end
    endtask

    // Byte k sits at pixel k/2, first byte of a pair at byte select 1
    task automatic check_row(input int row, input logic [31:0] seed);
        logic [11:0] addr;
        fill_expected_row(seed);
        for (int k = 0; k < LINE_BYTES; k++) begin
            addr = 12'(row * LINE_BYTES + (k / 2) * 2 + 1 - (k % 2));
            @(negedge clk_in);
            scan_addr = addr;
            @(negedge clk_in);  // Registered read
            checks_run++;
            if (scan_data !== exp_row[k]) begin
                report_error($sformatf("row %0d byte %0d", row, k), exp_row[k], scan_data);
            end
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("PASS %s", test_name);
            end else begin
                tests_failed++;
                $display("FAIL %s with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    // ****************************************
    // Trace driven sequence
    // ****************************************

    initial begin
        int               fd;
        int               count;
        int               assert_fails;
        string            kind;
        logic [31:0]      arg_a;
        logic [31:0]      arg_b;
        logic [31:0]      arg_c;
        logic [8*128-1:0] comment_line;

        reset        = 1'b1;
        uart_rx      = 1'b1;
        scan_addr    = '0;
        test_name    = "";
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks_run   = 0;

        fd = $fopen("led_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file led_trace.txt");
        end else begin
            repeat (2) @(posedge clk_in);
            @(negedge clk_in);
            reset = 1'b0;

            while ($fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "#": begin
                        count = $fgets(comment_line, fd);
                    end
                    "T": begin
                        close_test();
                        count = $fscanf(fd, "%s", test_name);
                        check_field_count(count, 1, kind);
                    end
                    "S": begin
                        count = $fscanf(fd, "%h", arg_a);
                        check_field_count(count, 1, kind);
                        send_byte(arg_a[7:0], 1'b0);
                    end
                    "X": begin
                        count = $fscanf(fd, "%h", arg_a);
                        check_field_count(count, 1, kind);
                        send_byte(arg_a[7:0], 1'b1);  // Low stop bit
                    end
                    "P": begin
                        count = $fscanf(fd, "%d %h", arg_a, arg_b);
                        check_field_count(count, 2, kind);
                        send_line(arg_a, arg_b);
                    end
                    "E": begin
                        count = $fscanf(fd, "%b %b %d", arg_a, arg_b, arg_c);
                        check_field_count(count, 3, kind);
                        check_outputs(arg_a[2:0], arg_b[5:0], arg_c[7:0]);
                    end
                    "M": begin
                        count = $fscanf(fd, "%d %h", arg_a, arg_b);
                        check_field_count(count, 2, kind);
                        check_row(arg_a, arg_b);
                    end
                    default: begin
                        $display("Unknown trace line kind %s in test %s", kind, test_name);
                        test_errors++;
                        total_errors++;
                    end
                endcase
            end
            close_test();
            $fclose(fd);

            assert_fails = dut.u_command_parser.u_led_asserts.fail_count;
            total_errors = total_errors + assert_fails;
            $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                     tests_run, tests_failed, checks_run, total_errors, assert_fails);
            if (total_errors == 0 && tests_run > 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// ==== uart_cmd_pkg.sv ====
package uart_cmd_pkg;

    // ****************************************
    // Command characters
    // ****************************************

    localparam logic [7:0] CMD_RED_ON     = "R";
    localparam logic [7:0] CMD_RED_OFF    = "r";
    localparam logic [7:0] CMD_GREEN_ON   = "G";
    localparam logic [7:0] CMD_GREEN_OFF  = "g";
    localparam logic [7:0] CMD_BLUE_ON    = "B";
    localparam logic [7:0] CMD_BLUE_OFF   = "b";
    localparam logic [7:0] CMD_PLANE_1    = "1"; // Toggles the top plane
    localparam logic [7:0] CMD_PLANE_2    = "2";
    localparam logic [7:0] CMD_PLANE_3    = "3";
    localparam logic [7:0] CMD_PLANE_4    = "4";
    localparam logic [7:0] CMD_PLANE_5    = "5";
    localparam logic [7:0] CMD_PLANE_6    = "6"; // Toggles the bottom plane
    localparam logic [7:0] CMD_PLANES_OFF = "0";
    localparam logic [7:0] CMD_PLANES_ON  = "9";
    localparam logic [7:0] CMD_LINE       = "L"; // Row byte and pixel data follow

    // Line load sequencing
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // Single-character commands
        ST_ROW  = 2'd1,  // Waiting for the row byte
        ST_DATA = 2'd2   // Collecting pixel bytes
    } line_state_e;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
    parameter int ticks_per_bit = led_cfg_pkg::UART_TICKS_PER_BIT
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       uart_rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_busy
);

    logic                             rx_meta;
    logic                             rx_sync;
    logic [$clog2(ticks_per_bit)-1:0] tick_cnt;
    logic [3:0]                       bit_idx;   // 0 start, 1-8 data, 9 stop, 10 tail
    logic [7:0]                       shift_reg;
    logic                             start_mid;
    logic                             bit_mid;
    logic                             tail_end;
    logic                             data_sample;
    logic                             stop_sample;

    // Midpoint of the start bit, counted from the falling edge
    assign start_mid = (tick_cnt == (ticks_per_bit - 1) / 2 - 1);
    // One full bit after the previous sample
    assign bit_mid   = (tick_cnt == ticks_per_bit - 1);
    // Last cycle of the stop bit
    assign tail_end  = (tick_cnt == ticks_per_bit - (ticks_per_bit - 1) / 2 - 2);

    assign data_sample = rx_busy && (bit_idx >= 4'd1) && (bit_idx <= 4'd8) && bit_mid;
    assign stop_sample = rx_busy && (bit_idx == 4'd9) && bit_mid;

    // Line synchronizer
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;  // Idle line is high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // ****************************************
    // Bit timing and framing
    // ****************************************

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_busy  <= 1'b0;
            rx_valid <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            if (!rx_busy) begin
                if (!rx_sync) begin  // Falling edge of a start bit
                    rx_busy  <= 1'b1;
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                end
            end else if (bit_idx == 4'd0) begin
                if (start_mid) begin
                    tick_cnt <= '0;
                    if (rx_sync) begin
                        rx_busy <= 1'b0;  // Glitch, not a start bit
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end
            end else if (data_sample) begin
                tick_cnt <= '0;
                bit_idx  <= bit_idx + 4'd1;
            end else if (stop_sample) begin
                tick_cnt <= '0;
                bit_idx  <= 4'd10;
                rx_valid <= rx_sync;  // Framing error drops the byte
            end else if (bit_idx == 4'd10 && tail_end) begin
                rx_busy <= 1'b0;
            end
        end
    end

    // Data shift, LSB first
    always_ff @(posedge clk_in) begin
        if (data_sample) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (stop_sample) begin
            rx_byte <= shift_reg;
        end
    end

endmodule
